// ==== verilog.f ====
rtl/pipe_isa_pkg.sv
rtl/pipe_stage_pkg.sv
rtl/issue_stage.sv
rtl/execute_stage.sv
rtl/ex_mem_reg.sv
rtl/mem_stage.sv
rtl/exec_pipe_top.sv
tb/exec_pipe_props.sv
tb/exec_pipe_tb.sv

// ==== tb/exec_pipe_tb.sv ====
/*
 * Testbench for exec_pipe_top. Expected results come from a model of the pipeline
 * rules; results lag issue by three edges and show up one per cycle.
 */

module exec_pipe_tb
    import pipe_isa_pkg::*, pipe_stage_pkg::*;
();

    localparam int dmem_depth   = 16;
    localparam int addr_w       = $clog2(dmem_depth);
    localparam int reset_cycles = 16;
    localparam int n_random     = 400;
    localparam int n_directed   = 18;
    localparam int n_flush      = 3;     // pipeline depth, also the bubbles ahead of the first op.
    localparam int n_ops        = dmem_depth + n_random + n_directed + n_flush;

    typedef struct packed {
        wb_t  wb;
        logic taken;
    } expect_t;

    logic            clk;
    logic            reset;
    iclass_e         iclass;
    alu_op_e         alu_op;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] store_data;
    reg_idx_t        rd;
    wb_t             wb;
    logic            branch_taken;

    logic [xlen-1:0] shadow [dmem_depth];    // model of the data memory.
    expect_t         exp_q [$];              // expected results still in the pipe.
    logic [31:0]     lfsr;
    logic            checking;
    int              n_issued;
    int              n_checks;

    exec_pipe_top #(.dmem_depth (dmem_depth)) i_dut (.*);

    always #4 clk = ~clk;

    // **********************************************************************
    // stimulus helpers and reference model
    // **********************************************************************
    function automatic logic [xlen-1:0] rand_bits(int n);
        logic [xlen-1:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);    // galois step.
            r    = {r[xlen-2:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [xlen-1:0] fill_pattern(logic [31:0] idx);
        return {idx ^ 32'h5a5a_c3c3, ~idx};
    endfunction

    function automatic expect_t ref_op(iclass_e c, alu_op_e op, logic [xlen-1:0] a,
                                       logic [xlen-1:0] b, logic [xlen-1:0] d, reg_idx_t r);
        expect_t         e;
        logic [xlen-1:0] res;
        int              idx;
        if (c == ic_load || c == ic_store) op = alu_add;
        else if (c == ic_branch) op = alu_sub;
        case (op)
            alu_add: res = a + b;
            alu_sub: res = a - b;
            alu_and: res = a & b;
            alu_or:  res = a | b;
            alu_xor: res = a ^ b;
            alu_sll: res = a << b[5:0];
            alu_srl: res = a >> b[5:0];
            default: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        endcase
        idx               = int'((res >> 3) % dmem_depth);
        e.wb.reg_write_en = (c == ic_alu || c == ic_load) && (r != '0);
        e.wb.rd           = r;
        e.wb.value        = (c == ic_load) ? shadow[idx] : res;
        e.taken           = (c == ic_branch) && (res == '0);
        if (c == ic_store) shadow[idx] = d;    // in order, so later loads see it.
        return e;
    endfunction

    task automatic stop_on_failure(string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_wb(wb_t exp, wb_t act);
        if (act.reg_write_en !== exp.reg_write_en)
            stop_on_failure($sformatf("ERR wb.reg_write_en expected %h actual %h",
                                      exp.reg_write_en, act.reg_write_en));
        else if (act.rd !== exp.rd)
            stop_on_failure($sformatf("ERR wb.rd expected %h actual %h", exp.rd, act.rd));
        else if (act.value !== exp.value)
            stop_on_failure($sformatf("ERR wb.value expected %h actual %h",
                                      exp.value, act.value));
    endtask

    task automatic check_branch(logic exp, logic act);
        if (act !== exp)
            stop_on_failure($sformatf("ERR branch_taken expected %h actual %h", exp, act));
    endtask

    // drives one operation now and returns one time unit after the next edge.
    task automatic issue_op(iclass_e c, alu_op_e op, logic [xlen-1:0] a, logic [xlen-1:0] b,
                            logic [xlen-1:0] d, reg_idx_t r);
        iclass     = c;
        alu_op     = op;
        op_a       = a;
        op_b       = b;
        store_data = d;
        rd         = r;
        exp_q.push_back(ref_op(c, op, a, b, d, r));
        n_issued++;
        @(posedge clk);
        #1;
    endtask

    task automatic issue_random();
        iclass_e         c;
        alu_op_e         op;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] d;
        c  = iclass_e'(3'(rand_bits(3) % 5));
        op = alu_op_e'(3'(rand_bits(3)));
        a  = rand_bits(xlen);
        b  = rand_bits(xlen);
        d  = rand_bits(xlen);
        if (c == ic_load || c == ic_store) begin
            a = rand_bits(addr_w) << 3;    // doubleword inside the memory.
            b = rand_bits(3);              // byte offset, dropped by the memory.
        end else if (c == ic_branch && rand_bits(1) == 1) begin
            b = a;                         // about half of the branches are taken.
        end
        issue_op(c, op, a, b, d, reg_idx_t'(rand_bits(5)));
    endtask

    // **********************************************************************
    // compare, stimulus and watchdog
    // **********************************************************************
    always @(negedge clk) begin
        expect_t e;
        if (checking) begin
            if (exp_q.size() == 0) begin
                stop_on_failure("no expected result left while the DUT was still checked");
            end else if (i_dut.u_mem.i_props.fail_count != 0) begin
                stop_on_failure("a bound assertion on pipeline control failed");
            end else begin
                e = exp_q.pop_front();
                check_wb(e.wb, wb);
                check_branch(e.taken, branch_taken);
                n_checks++;
            end
        end
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b0;
        iclass     = ic_nop;
        alu_op     = alu_add;
        op_a       = '0;
        op_b       = '0;
        store_data = '0;
        rd         = '0;
        lfsr       = 32'h67f4;
        checking   = 1'b0;
        n_issued   = 0;
        n_checks   = 0;
        #1;
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (n_flush) exp_q.push_back('0);    // stages still hold reset bubbles.
        checking = 1'b1;
        for (int i = 0; i < dmem_depth; i++) begin
            issue_op(ic_store, alu_add, 64'(i) << 3, '0, fill_pattern(i), reg_idx_t'(i + 1));
        end
        repeat (n_random) issue_random();
        issue_op(ic_nop, alu_add, 64'd1, 64'd2, '0, 5'd5);
        issue_op(ic_nop, alu_or, 64'd3, 64'd4, '0, 5'd6);
        issue_op(ic_alu, alu_add, '1, 64'd1, '0, 5'd1);        // wraps to zero.
        issue_op(ic_alu, alu_sub, '0, 64'd1, '0, 5'd2);
        issue_op(ic_alu, alu_and, 64'hf0f0_3c3c_ffff_0001, 64'h0ff0_c3c3_1234_ffff, '0, 5'd3);
        issue_op(ic_alu, alu_or, 64'hf000_0000_0000_000f, 64'h0123_4567_89ab_cd00, '0, 5'd4);
        issue_op(ic_alu, alu_xor, 64'haaaa_5555_aaaa_5555, '1, '0, 5'd5);
        issue_op(ic_alu, alu_sll, 64'd1, 64'd65, '0, 5'd6);    // shift amount is 1.
        issue_op(ic_alu, alu_srl, '1, 64'd127, '0, 5'd7);      // shift amount is 63.
        issue_op(ic_alu, alu_slt, '1, 64'd1, '0, 5'd8);        // -1 < 1.
        issue_op(ic_alu, alu_slt, 64'd1, '1, '0, 5'd9);
        issue_op(ic_alu, alu_add, 64'd7, 64'd8, '0, 5'd0);
        issue_op(ic_store, alu_add, 64'd40, '0, 64'hdead_beef_0bad_f00d, 5'd10);
        issue_op(ic_load, alu_xor, 64'd32, 64'd13, '0, 5'd11);    // word 5 again.
        issue_op(ic_load, alu_add, 64'd48, 64'd5, '0, 5'd12);
        issue_op(ic_load, alu_add, 64'(dmem_depth + 2) << 3, '0, '0, 5'd13);    // wraps.
        issue_op(ic_branch, alu_add, 64'h1234, 64'h1234, '0, 5'd14);
        issue_op(ic_branch, alu_add, 64'h1234, 64'h1235, '0, 5'd15);
        repeat (n_flush) issue_op(ic_nop, alu_add, '0, '0, '0, '0);
        if (i_dut.u_mem.i_props.fail_count != 0) begin
            stop_on_failure("a bound assertion on pipeline control failed");
        end else if (n_checks == n_issued && exp_q.size() == n_flush) begin
            $display("All tests passed");
            $finish;
        end else begin
            stop_on_failure("the number of checked results differs from the operations issued");
        end
    end

    initial begin
        repeat (reset_cycles + n_ops + 50) @(posedge clk);
        stop_on_failure("timeout: the run did not finish in the expected number of cycles");
    end

endmodule

// ==== tb/exec_pipe_props.sv ====
/*
 * Pipeline control checks, bound into mem_stage and sampled at rising clock edges.
 */

module exec_pipe_props
    import pipe_stage_pkg::*;
(
    input logic    clk,
    input logic    reset,
    input ex_mem_t ex_mem,
    input wb_t     wb,
    input logic    branch_taken
);

    int unsigned fail_count = 0;    // failed assertions so far.

    a_rw_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(ex_mem.ctrl.mem_read && ex_mem.ctrl.mem_write))
    else begin
        fail_count++;
        $error("mem_read and mem_write set together");
    end

    // x0 is never written and a branch never writes back.
    a_no_bad_write: assert property (@(posedge clk) disable iff (reset)
        !(wb.reg_write_en && (wb.rd == '0 || branch_taken)))
    else begin
        fail_count++;
        $error("reg_write_en with rd zero or with branch_taken");
    end

    a_reset_clear: assert property (@(posedge clk)
        reset |-> (ex_mem.ctrl == '0 && !wb.reg_write_en && !branch_taken))
    else begin
        fail_count++;
        $error("control bits not clear during reset");
    end

endmodule

bind mem_stage exec_pipe_props i_props (
    .clk          (clk),
    .reset        (reset),
    .ex_mem       (ex_mem),
    .wb           (wb),
    .branch_taken (branch_taken)
);

// ==== rtl/exec_pipe_top.sv ====
/*
 * Execute, memory and writeback half of the pipeline. No hazard handling or
 * stalls; results appear three cycles after an operation is sampled.
 */

module exec_pipe_top
    import pipe_isa_pkg::*, pipe_stage_pkg::*;
#(
    parameter int dmem_depth = 16    // doublewords, power of two.
)
(
    input  logic            clk,
    input  logic            reset,
    input  iclass_e         iclass,
    input  alu_op_e         alu_op,
    input  logic [xlen-1:0] op_a,
    input  logic [xlen-1:0] op_b,
    input  logic [xlen-1:0] store_data,
    input  reg_idx_t        rd,
    output wb_t             wb,
    output logic            branch_taken
);

    id_ex_t  id_ex;     // issue to execute.
    ex_mem_t ex_in;     // execute results before the EX/MEM register.
    ex_mem_t ex_mem;    // memory stage input.

    issue_stage u_issue (
        .clk        (clk),
        .reset      (reset),
        .iclass     (iclass),
        .alu_op     (alu_op),
        .op_a       (op_a),
        .op_b       (op_b),
        .store_data (store_data),
        .rd         (rd),
        .id_ex      (id_ex)
    );

    execute_stage u_execute (
        .id_ex (id_ex),
        .ex_in (ex_in)
    );

    ex_mem_reg u_ex_mem (
        .clk    (clk),
        .reset  (reset),
        .ex_in  (ex_in),
        .ex_mem (ex_mem)
    );

    mem_stage #(
        .dmem_depth (dmem_depth)
    ) u_mem (
        .clk          (clk),
        .reset        (reset),
        .ex_mem       (ex_mem),
        .wb           (wb),
        .branch_taken (branch_taken)
    );

endmodule

// ==== rtl/mem_stage.sv ====
/*
 * Doubleword data memory and MEM/WB register. dmem_depth must be a power of
 * two from 2 to 1024; higher address bits wrap. Memory contents have no reset.
 */

module mem_stage
    import pipe_isa_pkg::*, pipe_stage_pkg::*;
#(
    parameter int dmem_depth = 16
)
(
    input  logic    clk,
    input  logic    reset,
    input  ex_mem_t ex_mem,
    output wb_t     wb,
    output logic    branch_taken
);

    localparam int addr_w = $clog2(dmem_depth);

    logic [xlen-1:0]   dmem [dmem_depth];
    logic [addr_w-1:0] addr;          // doubleword index.
    logic [xlen-1:0]   load_value;
    logic [xlen-1:0]   wb_value;
    logic              taken;

    // byte offset bits are dropped, the rest wraps modulo the depth.
    assign addr = ex_mem.alu_out[dw_offset +: addr_w];

    // **********************************************************************
    // data memory
    // **********************************************************************

    // a store lands at the edge that moves the next operation into EX/MEM,
    // so a load right behind it reads the new word.
    always_ff @(posedge clk) begin
        if (ex_mem.ctrl.mem_write) begin
            dmem[addr] <= ex_mem.data;
        end
    end

    assign load_value = ex_mem.ctrl.mem_read ? dmem[addr] : '0;    // asynchronous read.

    // **********************************************************************
    // writeback select and branch outcome
    // **********************************************************************
    assign wb_value = ex_mem.ctrl.mem_to_reg ? load_value : ex_mem.alu_out;
    assign taken    = ex_mem.ctrl.branch & ex_mem.z_flag;    // beq only.

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb           <= '0;
            branch_taken <= 1'b0;
        end else begin
            wb.reg_write_en <= ex_mem.ctrl.reg_write_en;
            wb.rd           <= ex_mem.rd;
            wb.value        <= wb_value;
            branch_taken    <= taken;
        end
    end

endmodule

// ==== rtl/ex_mem_reg.sv ====
/*
 * EX/MEM pipeline register. Every field, data included, clears on reset.
 */

module ex_mem_reg
    import pipe_stage_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  ex_mem_t ex_in,
    output ex_mem_t ex_mem
);

    // **********************************************************************
    // register the execute results for the memory stage
    // **********************************************************************
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem.ctrl    <= '0;    // a bubble enters the memory stage.
            ex_mem.z_flag  <= 1'b0;
            ex_mem.alu_out <= '0;
            ex_mem.data    <= '0;
            ex_mem.rd      <= '0;
        end else begin
            // memory and writeback controls move one stage.
            ex_mem.ctrl.mem_read     <= ex_in.ctrl.mem_read;
            ex_mem.ctrl.mem_write    <= ex_in.ctrl.mem_write;
            ex_mem.ctrl.mem_to_reg   <= ex_in.ctrl.mem_to_reg;
            ex_mem.ctrl.reg_write_en <= ex_in.ctrl.reg_write_en;
            ex_mem.ctrl.branch       <= ex_in.ctrl.branch;
            ex_mem.z_flag            <= ex_in.z_flag;
            ex_mem.alu_out           <= ex_in.alu_out;    // also the memory address.
            ex_mem.data              <= ex_in.data;
            ex_mem.rd                <= ex_in.rd;
        end
    end

endmodule

// ==== rtl/execute_stage.sv ====
/*
 * Combinational 64-bit ALU. Shift amounts use only the low 6 bits of op_b
 * and slt compares as signed numbers.
 */

module execute_stage
    import pipe_isa_pkg::*, pipe_stage_pkg::*;
(
    input  id_ex_t  id_ex,
    output ex_mem_t ex_in
);

    localparam int shamt_w = $clog2(xlen);

    logic [xlen-1:0]    alu_res;
    logic [shamt_w-1:0] shamt;
    logic               lt;

    assign shamt = id_ex.op_b[shamt_w-1:0];
    assign lt    = $signed(id_ex.op_a) < $signed(id_ex.op_b);

    always_comb begin
        case (id_ex.alu_op)
            alu_add: alu_res = id_ex.op_a + id_ex.op_b;
            alu_sub: alu_res = id_ex.op_a - id_ex.op_b;
            alu_and: alu_res = id_ex.op_a & id_ex.op_b;
            alu_or:  alu_res = id_ex.op_a | id_ex.op_b;
            alu_xor: alu_res = id_ex.op_a ^ id_ex.op_b;
            alu_sll: alu_res = id_ex.op_a << shamt;
            alu_srl: alu_res = id_ex.op_a >> shamt;    // logical, zero fill.
            alu_slt: alu_res = {{(xlen-1){1'b0}}, lt};
            default: alu_res = '0;
        endcase
    end

    // payload for the EX/MEM register.
    always_comb begin
        ex_in.ctrl    = id_ex.ctrl;
        ex_in.z_flag  = (alu_res == '0);    // branch compare uses this.
        ex_in.alu_out = alu_res;
        ex_in.data    = id_ex.data;
        ex_in.rd      = id_ex.rd;
    end

endmodule

// ==== rtl/issue_stage.sv ====
/*
 * Class decode and ID/EX register. Writes to register zero are dropped here,
 * so later stages never see reg_write_en with rd of zero.
 */

module issue_stage
    import pipe_isa_pkg::*, pipe_stage_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  iclass_e         iclass,
    input  alu_op_e         alu_op,
    input  logic [xlen-1:0] op_a,
    input  logic [xlen-1:0] op_b,
    input  logic [xlen-1:0] store_data,
    input  reg_idx_t        rd,
    output id_ex_t          id_ex
);

    stage_ctrl_t ctrl;      // decoded control bits.
    alu_op_e     eff_op;    // opcode the ALU will actually run.

    // **********************************************************************
    // class decode
    // **********************************************************************
    always_comb begin
        ctrl   = '0;
        eff_op = alu_op;
        case (iclass)
            ic_alu: begin
                ctrl.reg_write_en = 1'b1;
            end
            ic_load: begin
                ctrl.mem_read     = 1'b1;
                ctrl.mem_to_reg   = 1'b1;
                ctrl.reg_write_en = 1'b1;
                eff_op            = alu_add;   // address is base plus offset.
            end
            ic_store: begin
                ctrl.mem_write = 1'b1;
                eff_op         = alu_add;
            end
            ic_branch: begin
                ctrl.branch = 1'b1;
                eff_op      = alu_sub;         // equal operands give a zero result.
            end
            default: begin
                ctrl = '0;                     // nop and unknown classes are bubbles.
            end
        endcase
        if (rd == '0) begin
            ctrl.reg_write_en = 1'b0;          // x0 is hardwired to zero.
        end
    end

    // **********************************************************************
    // ID/EX register
    // **********************************************************************
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex <= '0;
        end else begin
            id_ex.ctrl   <= ctrl;
            id_ex.alu_op <= eff_op;
            id_ex.op_a   <= op_a;
            id_ex.op_b   <= op_b;
            id_ex.data   <= store_data;
            id_ex.rd     <= rd;
        end
    end

endmodule

// ==== rtl/pipe_stage_pkg.sv ====
/*
 * Payloads that travel between pipeline stages.
 * All control bits are plain levels; a zero ctrl field marks a bubble.
 */

package pipe_stage_pkg;

    import pipe_isa_pkg::*;

    // control bits that follow an operation down the pipe.
    typedef struct packed {
        logic mem_read;
        logic mem_write;
        logic mem_to_reg;
        logic reg_write_en;
        logic branch;
    } stage_ctrl_t;

    typedef struct packed {
        stage_ctrl_t       ctrl;
        alu_op_e           alu_op;    // effective opcode after class decode.
        logic [xlen-1:0]   op_a;
        logic [xlen-1:0]   op_b;
        logic [xlen-1:0]   data;      // store data.
        reg_idx_t          rd;
    } id_ex_t;

    typedef struct packed {
        stage_ctrl_t       ctrl;
        logic              z_flag;    // ALU result was zero.
        logic [xlen-1:0]   alu_out;
        logic [xlen-1:0]   data;
        reg_idx_t          rd;
    } ex_mem_t;

    typedef struct packed {
        logic              reg_write_en;
        reg_idx_t          rd;
        logic [xlen-1:0]   value;
    } wb_t;

endpackage

// ==== rtl/pipe_isa_pkg.sv ====
/*
 * ISA level types for the back half of the integer pipeline.
 * Only doubleword data is supported, so the low address bits carry no meaning.
 */

package pipe_isa_pkg;

    localparam int xlen      = 64;  // integer data width.
    localparam int reg_idx_w = 5;   // 32 architectural registers.
    localparam int dw_offset = 3;   // byte offset bits inside one doubleword.

    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // instruction class as handed over by decode.
    typedef enum logic [2:0] {
        ic_nop    = 3'd0,   // bubble, no side effects.
        ic_alu    = 3'd1,
        ic_load   = 3'd2,
        ic_store  = 3'd3,
        ic_branch = 3'd4
    } iclass_e;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_sll = 3'd5,
        alu_srl = 3'd6,
        alu_slt = 3'd7      // signed compare, result is 0 or 1.
    } alu_op_e;

endpackage
